// ==== Bender.yml ====
package:
  name: ccu_mhq

sources:
  - hw/mhq_pkg.sv
  - hw/mhq_entry.sv
  - hw/mhq_lookup.sv
  - hw/mhq_fill_select.sv
  - hw/ccu_line_fetch.sv
  - hw/ccu_mhq.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/wb_mem_model.sv
      - sim/tb_ccu_mhq.sv

// ==== ccu_mhq.f ====
hw/mhq_pkg.sv
hw/mhq_entry.sv
hw/mhq_lookup.sv
hw/mhq_fill_select.sv
hw/ccu_line_fetch.sv
hw/ccu_mhq.sv
sim/tb_clkgen.sv
sim/wb_mem_model.sv
sim/tb_ccu_mhq.sv

// ==== hw/ccu_line_fetch.sv ====
`timescale 1ns/1ps

module ccu_line_fetch #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 16,
    parameter int MHQ_DEPTH  = 4,

    localparam int OFFSET_W    = $clog2(LINE_SIZE),
    localparam int LINE_ADDR_W = ADDR_WIDTH - OFFSET_W,
    localparam int LINE_W      = LINE_SIZE * 8
)(
    input  logic                                  clk,
    input  logic                                  i_rst,

    input  logic [MHQ_DEPTH-1:0]                  i_entry_valid,
    input  logic [MHQ_DEPTH-1:0]                  i_entry_complete,
    input  logic [MHQ_DEPTH-1:0][LINE_ADDR_W-1:0] i_entry_addr,

    output logic [MHQ_DEPTH-1:0]                  o_ccu_done,
    output logic [LINE_W-1:0]                     o_ccu_data,

    // Wishbone classic read master
    output logic                                  o_wb_cyc,
    output logic                                  o_wb_stb,
    output logic [ADDR_WIDTH-1:0]                 o_wb_adr,
    input  logic [mhq_pkg::WB_DATA_WIDTH-1:0]     i_wb_dat,
    input  logic                                  i_wb_ack
);

    // One word per beat, the beat index sits between line address and byte offset
    // This needs at least two beats per line, so LINE_SIZE of 8 or more
    localparam int NUM_BEATS = LINE_W / mhq_pkg::WB_DATA_WIDTH;
    localparam int BEAT_W    = OFFSET_W - 2;
    localparam int IDX_W     = (MHQ_DEPTH > 1) ? $clog2(MHQ_DEPTH) : 1;

    mhq_pkg::fetch_state_e  state_r;

    logic [MHQ_DEPTH-1:0]   serviced_r;
    logic [MHQ_DEPTH-1:0]   pending;
    logic [IDX_W-1:0]       pick_idx;
    logic                   pick_any;

    logic [IDX_W-1:0]       idx_r;
    logic [LINE_ADDR_W-1:0] addr_r;
    logic [BEAT_W-1:0]      beat_r;
    logic [LINE_W-1:0]      line_r;
    logic                   last_ack;

    // A store can mask complete for a cycle, the serviced bit keeps such an
    // entry from looking pending again until the entry has been freed
    assign pending = i_entry_valid & ~i_entry_complete & ~serviced_r;

    // Walk from the top down so the lowest pending index wins
    always_comb begin
        pick_idx = '0;
        pick_any = 1'b0;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = IDX_W'(i);
                pick_any = 1'b1;
            end
        end
    end

    assign last_ack = i_wb_ack && (beat_r == BEAT_W'(NUM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r    <= mhq_pkg::FETCH_IDLE;
            serviced_r <= '0;
        end else begin
            // Set by done, dropped as soon as the entry goes invalid
            serviced_r <= i_entry_valid & (serviced_r | o_ccu_done);
            case (state_r)
                mhq_pkg::FETCH_IDLE: if (pick_any) state_r <= mhq_pkg::FETCH_BUS;
                mhq_pkg::FETCH_BUS:  if (last_ack) state_r <= mhq_pkg::FETCH_DONE;
                mhq_pkg::FETCH_DONE: state_r <= mhq_pkg::FETCH_IDLE;
                default:             state_r <= mhq_pkg::FETCH_IDLE;
            endcase
        end
    end

    // Latch the target in idle, then shift each acked word in from the top,
    // so after the last beat word k sits at bytes 4k to 4k+3
    always_ff @(posedge clk) begin
        if (state_r == mhq_pkg::FETCH_IDLE && pick_any) begin
            idx_r  <= pick_idx;
            addr_r <= i_entry_addr[pick_idx];
            beat_r <= '0;
        end
        if (state_r == mhq_pkg::FETCH_BUS && i_wb_ack) begin
            line_r <= {i_wb_dat, line_r[LINE_W-1:mhq_pkg::WB_DATA_WIDTH]};
            beat_r <= beat_r + 1'b1;
        end
    end

    // cyc and stb stay up across beats, the address only moves on ack
    assign o_wb_cyc = (state_r == mhq_pkg::FETCH_BUS);
    assign o_wb_stb = (state_r == mhq_pkg::FETCH_BUS);
    assign o_wb_adr = {addr_r, beat_r, 2'b00};

    // The entry turns complete on the edge that ends the done state
    assign o_ccu_done = (state_r == mhq_pkg::FETCH_DONE) ?
                        (MHQ_DEPTH'(1) << idx_r) : '0;
    assign o_ccu_data = line_r;

endmodule

// ==== hw/ccu_mhq.sv ====
`timescale 1ns/1ps

module ccu_mhq #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 16,
    parameter int MHQ_DEPTH  = 4,

    localparam int OFFSET_W    = $clog2(LINE_SIZE),
    localparam int LINE_ADDR_W = ADDR_WIDTH - OFFSET_W,
    localparam int LINE_W      = LINE_SIZE * 8
)(
    input  logic                              clk,
    input  logic                              i_rst,

    // Miss requests from the cache
    input  logic                              i_req_valid,
    input  logic                              i_req_we,
    input  logic [LINE_ADDR_W-1:0]            i_req_addr,
    input  logic [LINE_W-1:0]                 i_req_wr_data,
    input  logic [LINE_SIZE-1:0]              i_req_byte_sel,
    output logic                              o_req_ready,

    // Completed lines back to the cache
    output logic                              o_fill_valid,
    output logic                              o_fill_dirty,
    output logic [LINE_ADDR_W-1:0]            o_fill_addr,
    output logic [LINE_W-1:0]                 o_fill_data,
    input  logic                              i_fill_ready,

    // Memory side
    output logic                              o_wb_cyc,
    output logic                              o_wb_stb,
    output logic [ADDR_WIDTH-1:0]             o_wb_adr,
    input  logic [mhq_pkg::WB_DATA_WIDTH-1:0] i_wb_dat,
    input  logic                              i_wb_ack
);

    logic [MHQ_DEPTH-1:0]                  entry_valid;
    logic [MHQ_DEPTH-1:0]                  entry_complete;
    logic [MHQ_DEPTH-1:0]                  entry_dirty;
    logic [MHQ_DEPTH-1:0][LINE_ADDR_W-1:0] entry_addr;
    logic [MHQ_DEPTH-1:0][LINE_W-1:0]      entry_data;

    logic [MHQ_DEPTH-1:0]                  update_en;
    logic [MHQ_DEPTH-1:0]                  ccu_done;
    logic [LINE_W-1:0]                     ccu_data;
    logic [MHQ_DEPTH-1:0]                  fill_launched;

    // Request payload and fetched line go to every entry, the one-hot
    // enables decide which entry actually takes them
    for (genvar g = 0; g < MHQ_DEPTH; g++) begin : g_entry
        mhq_entry #(
            .ADDR_WIDTH (ADDR_WIDTH),
            .LINE_SIZE  (LINE_SIZE)
        ) u_entry (
            .clk               (clk),
            .i_rst             (i_rst),
            .i_update_en       (update_en[g]),
            .i_update_we       (i_req_we),
            .i_update_wr_data  (i_req_wr_data),
            .i_update_byte_sel (i_req_byte_sel),
            .i_update_addr     (i_req_addr),
            .i_ccu_done        (ccu_done[g]),
            .i_ccu_data        (ccu_data),
            .i_fill_launched   (fill_launched[g]),
            .o_valid           (entry_valid[g]),
            .o_complete        (entry_complete[g]),
            .o_dirty           (entry_dirty[g]),
            .o_addr            (entry_addr[g]),
            .o_data            (entry_data[g])
        );
    end

    mhq_lookup #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_SIZE  (LINE_SIZE),
        .MHQ_DEPTH  (MHQ_DEPTH)
    ) u_lookup (
        .i_req_valid   (i_req_valid),
        .i_req_addr    (i_req_addr),
        .i_entry_valid (entry_valid),
        .i_entry_addr  (entry_addr),
        .o_update_en   (update_en),
        .o_req_ready   (o_req_ready)
    );

    ccu_line_fetch #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_SIZE  (LINE_SIZE),
        .MHQ_DEPTH  (MHQ_DEPTH)
    ) u_fetch (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_entry_valid    (entry_valid),
        .i_entry_complete (entry_complete),
        .i_entry_addr     (entry_addr),
        .o_ccu_done       (ccu_done),
        .o_ccu_data       (ccu_data),
        .o_wb_cyc         (o_wb_cyc),
        .o_wb_stb         (o_wb_stb),
        .o_wb_adr         (o_wb_adr),
        .i_wb_dat         (i_wb_dat),
        .i_wb_ack         (i_wb_ack)
    );

    mhq_fill_select #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_SIZE  (LINE_SIZE),
        .MHQ_DEPTH  (MHQ_DEPTH)
    ) u_fill_sel (
        .i_entry_complete (entry_complete),
        .i_entry_dirty    (entry_dirty),
        .i_entry_addr     (entry_addr),
        .i_entry_data     (entry_data),
        .i_fill_ready     (i_fill_ready),
        .o_fill_valid     (o_fill_valid),
        .o_fill_dirty     (o_fill_dirty),
        .o_fill_addr      (o_fill_addr),
        .o_fill_data      (o_fill_data),
        .o_fill_launched  (fill_launched)
    );

endmodule

// ==== hw/mhq_entry.sv ====
`timescale 1ns/1ps

module mhq_entry #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 16,

    localparam int OFFSET_W    = $clog2(LINE_SIZE),
    localparam int LINE_ADDR_W = ADDR_WIDTH - OFFSET_W,
    localparam int LINE_W      = LINE_SIZE * 8
)(
    input  logic                   clk,
    input  logic                   i_rst,

    // Allocation or merge of a request into this entry
    input  logic                   i_update_en,
    input  logic                   i_update_we,
    input  logic [LINE_W-1:0]      i_update_wr_data,
    input  logic [LINE_SIZE-1:0]   i_update_byte_sel,
    input  logic [LINE_ADDR_W-1:0] i_update_addr,

    // Line returned by the fetcher
    input  logic                   i_ccu_done,
    input  logic [LINE_W-1:0]      i_ccu_data,

    // The fill port has taken this entry
    input  logic                   i_fill_launched,

    output logic                   o_valid,
    output logic                   o_complete,
    output logic                   o_dirty,
    output logic [LINE_ADDR_W-1:0] o_addr,
    output logic [LINE_W-1:0]      o_data
);

    mhq_pkg::mhq_state_e    state_r;
    mhq_pkg::mhq_state_e    state_next;

    logic                   dirty_r;
    logic [LINE_ADDR_W-1:0] addr_r;
    logic [LINE_W-1:0]      data_r;
    logic [LINE_W-1:0]      data_next;
    logic [LINE_SIZE-1:0]   mask_r;
    logic [LINE_SIZE-1:0]   mask_next;

    logic                   allocating;
    logic                   store_merge;
    logic [LINE_SIZE-1:0]   byte_wr;

    // Entry FSM, one step per event, launch returns the entry to the free pool
    always_comb begin
        state_next = state_r;
        case (state_r)
            mhq_pkg::MHQ_INVALID:  if (i_update_en) state_next = mhq_pkg::MHQ_VALID;
            mhq_pkg::MHQ_VALID:    if (i_ccu_done) state_next = mhq_pkg::MHQ_COMPLETE;
            mhq_pkg::MHQ_COMPLETE: if (i_fill_launched) state_next = mhq_pkg::MHQ_INVALID;
            default:               state_next = mhq_pkg::MHQ_INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= mhq_pkg::MHQ_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // An update to a free entry is a new allocation, anything else is a merge
    assign allocating  = i_update_en & (state_r == mhq_pkg::MHQ_INVALID);
    assign store_merge = i_update_en & i_update_we;
    assign byte_wr     = {LINE_SIZE{store_merge}} & i_update_byte_sel;

    // A fresh allocation starts clean unless the allocating request is itself a store
    always_ff @(posedge clk) begin
        if (i_update_en) begin
            dirty_r <= i_update_we | (~allocating & dirty_r);
        end
        if (allocating) begin
            addr_r <= i_update_addr;
        end
    end

    // Store bytes land first and mark the mask
    // The fetched line then only fills bytes that no store has touched,
    // which also covers a store that merges on the same cycle as done
    always_comb begin
        mask_next = allocating ? '0 : mask_r;
        data_next = data_r;
        for (int b = 0; b < LINE_SIZE; b++) begin
            if (byte_wr[b]) begin
                data_next[b*8 +: 8] = i_update_wr_data[b*8 +: 8];
                mask_next[b]        = 1'b1;
            end
            if (i_ccu_done && !mask_next[b]) begin
                data_next[b*8 +: 8] = i_ccu_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_r <= data_next;
        mask_r <= mask_next;
    end

    // Complete is hidden while a store writes the line, so a stale copy never launches
    assign o_valid    = (state_r != mhq_pkg::MHQ_INVALID);
    assign o_complete = (state_r == mhq_pkg::MHQ_COMPLETE) & ~store_merge;
    assign o_dirty    = dirty_r;
    assign o_addr     = addr_r;
    assign o_data     = data_r;

endmodule

// ==== hw/mhq_fill_select.sv ====
`timescale 1ns/1ps

module mhq_fill_select #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 16,
    parameter int MHQ_DEPTH  = 4,

    localparam int OFFSET_W    = $clog2(LINE_SIZE),
    localparam int LINE_ADDR_W = ADDR_WIDTH - OFFSET_W,
    localparam int LINE_W      = LINE_SIZE * 8
)(
    input  logic [MHQ_DEPTH-1:0]                  i_entry_complete,
    input  logic [MHQ_DEPTH-1:0]                  i_entry_dirty,
    input  logic [MHQ_DEPTH-1:0][LINE_ADDR_W-1:0] i_entry_addr,
    input  logic [MHQ_DEPTH-1:0][LINE_W-1:0]      i_entry_data,

    input  logic                                  i_fill_ready,
    output logic                                  o_fill_valid,
    output logic                                  o_fill_dirty,
    output logic [LINE_ADDR_W-1:0]                o_fill_addr,
    output logic [LINE_W-1:0]                     o_fill_data,

    output logic [MHQ_DEPTH-1:0]                  o_fill_launched
);

    logic [MHQ_DEPTH-1:0] sel;
    logic                 found;

    // Fixed priority, lowest index first, the chosen entry drives the fill port
    always_comb begin
        sel          = '0;
        found        = 1'b0;
        o_fill_dirty = 1'b0;
        o_fill_addr  = '0;
        o_fill_data  = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (i_entry_complete[i] && !found) begin
                sel[i]       = 1'b1;
                found        = 1'b1;
                o_fill_dirty = i_entry_dirty[i];
                o_fill_addr  = i_entry_addr[i];
                o_fill_data  = i_entry_data[i];
            end
        end
    end

    assign o_fill_valid = found;

    // Handshake completes on this edge, the entry frees itself on the same edge
    assign o_fill_launched = sel & {MHQ_DEPTH{i_fill_ready}};

endmodule

// ==== hw/mhq_lookup.sv ====
`timescale 1ns/1ps

module mhq_lookup #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 16,
    parameter int MHQ_DEPTH  = 4,

    localparam int OFFSET_W    = $clog2(LINE_SIZE),
    localparam int LINE_ADDR_W = ADDR_WIDTH - OFFSET_W
)(
    input  logic                                   i_req_valid,
    input  logic [LINE_ADDR_W-1:0]                 i_req_addr,

    input  logic [MHQ_DEPTH-1:0]                   i_entry_valid,
    input  logic [MHQ_DEPTH-1:0][LINE_ADDR_W-1:0]  i_entry_addr,

    output logic [MHQ_DEPTH-1:0]                   o_update_en,
    output logic                                   o_req_ready
);

    logic [MHQ_DEPTH-1:0] hit;
    logic [MHQ_DEPTH-1:0] free_sel;
    logic                 any_hit;
    logic                 any_free;
    logic                 req_take;

    // Compare the request line against every occupied entry
    // At most one entry holds a given line, so the hit vector is one-hot or zero
    always_comb begin
        hit = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            hit[i] = i_entry_valid[i] && (i_entry_addr[i] == i_req_addr);
        end
    end

    // Lowest-index free entry, used only when nothing hits
    always_comb begin
        free_sel = '0;
        any_free = 1'b0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (!i_entry_valid[i] && !any_free) begin
                free_sel[i] = 1'b1;
                any_free    = 1'b1;
            end
        end
    end

    assign any_hit = |hit;

    // A hit can always merge, a miss needs a free slot
    assign o_req_ready = any_hit | any_free;
    assign req_take    = i_req_valid & o_req_ready;

    // Merge wins over allocation so one line never owns two entries
    assign o_update_en = !req_take ? '0 :
                         any_hit   ? hit : free_sel;

endmodule

// ==== hw/mhq_pkg.sv ====
package mhq_pkg;

    // State of one miss handling queue entry
    // INVALID means the entry is free and may be allocated
    // VALID means a line is allocated and waits for, or is under, a fetch
    // COMPLETE means the line data is final and waits for the fill port
    typedef enum logic [1:0] {
        MHQ_INVALID  = 2'b00,
        MHQ_VALID    = 2'b01,
        MHQ_COMPLETE = 2'b10
    } mhq_state_e;

    // State of the line fetcher
    // IDLE looks for the lowest pending entry
    // BUS runs the Wishbone read beats for the latched line
    // DONE pulses the done strobe of the latched entry for one cycle
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'b00,
        FETCH_BUS  = 2'b01,
        FETCH_DONE = 2'b10
    } fetch_state_e;

    // Width of the Wishbone data bus toward memory
    // Every bus beat moves one word of this width
    localparam int WB_DATA_WIDTH = 32;

endpackage

// ==== sim/tb_ccu_mhq.sv ====
`timescale 1ns/1ps

module tb_ccu_mhq;

    localparam int          ADDR_WIDTH     = 32;
    localparam int          LINE_SIZE      = 16;
    localparam int          MHQ_DEPTH      = 4;
    localparam int          LINE_ADDR_W    = ADDR_WIDTH - $clog2(LINE_SIZE);
    localparam int          LINE_W         = LINE_SIZE * 8;
    localparam int          BEATS          = LINE_SIZE / 4;
    localparam int          BEAT_W         = $clog2(BEATS);
    // Each of about 40 requests takes at most some 60 cycles to be fetched and filled
    localparam int          MAX_REQUESTS   = 40;
    localparam int          REQ_CYCLES     = 60;
    localparam int          TIMEOUT_CYCLES = MAX_REQUESTS * REQ_CYCLES;
    localparam logic [31:0] MEM_XOR        = 32'h5a5a0000;

    logic                              clk;
    logic                              rst;
    logic                              req_valid;
    logic                              req_we;
    logic                              req_ready;
    logic [LINE_ADDR_W-1:0]            req_addr;
    logic [LINE_W-1:0]                 req_wr_data;
    logic [LINE_SIZE-1:0]              req_byte_sel;
    logic                              fill_valid;
    logic                              fill_dirty;
    logic                              fill_ready;
    logic [LINE_ADDR_W-1:0]            fill_addr;
    logic [LINE_W-1:0]                 fill_data;
    logic                              wb_cyc;
    logic                              wb_stb;
    logic                              wb_ack;
    logic [ADDR_WIDTH-1:0]             wb_adr;
    logic [mhq_pkg::WB_DATA_WIDTH-1:0] wb_dat;

    // Expected line and dirty bit of every line that has a miss in flight
    logic [LINE_W-1:0] exp_line [logic [LINE_ADDR_W-1:0]];
    logic              exp_dirty [logic [LINE_ADDR_W-1:0]];

    int          errors = 0;
    int          requests = 0;
    int          fills = 0;
    int          acks = 0;
    int          cycle_cnt;
    logic [31:0] rng = 32'h98a71709;

    tb_clkgen #(.PERIOD_NS(20.0)) u_clkgen (.o_clk(clk));

    ccu_mhq #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_SIZE  (LINE_SIZE),
        .MHQ_DEPTH  (MHQ_DEPTH)
    ) dut0 (
        .clk            (clk),
        .i_rst          (rst),
        .i_req_valid    (req_valid),
        .i_req_we       (req_we),
        .i_req_addr     (req_addr),
        .i_req_wr_data  (req_wr_data),
        .i_req_byte_sel (req_byte_sel),
        .o_req_ready    (req_ready),
        .o_fill_valid   (fill_valid),
        .o_fill_dirty   (fill_dirty),
        .o_fill_addr    (fill_addr),
        .o_fill_data    (fill_data),
        .i_fill_ready   (fill_ready),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_adr       (wb_adr),
        .i_wb_dat       (wb_dat),
        .i_wb_ack       (wb_ack)
    );

    wb_mem_model #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_XOR   (MEM_XOR)
    ) u_mem (
        .clk      (clk),
        .i_rst    (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_adr (wb_adr),
        .o_wb_dat (wb_dat),
        .o_wb_ack (wb_ack)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory content of a whole line
    // Word k is the pattern of byte address {line, k, 2'b00}
    function automatic logic [LINE_W-1:0] mem_line(input logic [LINE_ADDR_W-1:0] line);
        logic [LINE_W-1:0]     data;
        logic [ADDR_WIDTH-1:0] adr;
        for (int k = 0; k < BEATS; k++) begin
            adr              = {line, BEAT_W'(k), 2'b00};
            data[k*32 +: 32] = adr ^ MEM_XOR;
        end
        return data;
    endfunction

    task automatic expect_equal(input string name, input logic [LINE_W-1:0] got,
                                input logic [LINE_W-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %0h got %0h", name, exp, got);
        end
    endtask

    // Drives a request on the falling edge and holds it until the DUT takes it
    task automatic send_request(input logic we, input logic [LINE_ADDR_W-1:0] addr,
                                input logic [LINE_W-1:0] data,
                                input logic [LINE_SIZE-1:0] sel);
        req_valid    = 1'b1;
        req_we       = we;
        req_addr     = addr;
        req_wr_data  = data;
        req_byte_sel = sel;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Wishbone master rules and fill port stability are sampled at the rising edge
    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            errors++;
            $display("Error: o_wb_cyc expected 1 got %0h", $sampled(wb_cyc));
        end
    assert property (@(posedge clk) disable iff (rst) wb_stb && !wb_ack |=> wb_stb)
        else begin
            errors++;
            $display("Error: o_wb_stb expected 1 got %0h", $sampled(wb_stb));
        end
    assert property (@(posedge clk) disable iff (rst) wb_stb && !wb_ack |=> $stable(wb_adr))
        else begin
            errors++;
            $display("Error: o_wb_adr expected %0h got %0h", $past(wb_adr), $sampled(wb_adr));
        end
    assert property (@(posedge clk) disable iff (rst) fill_valid && !fill_ready |=> fill_valid)
        else begin
            errors++;
            $display("Error: o_fill_valid expected 1 got 0");
        end
    assert property (@(posedge clk) disable iff (rst)
                     fill_valid && !fill_ready |=> $stable(fill_addr))
        else begin
            errors++;
            $display("Error: o_fill_addr expected %0h got %0h", $past(fill_addr),
                     $sampled(fill_addr));
        end
    assert property (@(posedge clk) disable iff (rst)
                     fill_valid && !fill_ready |=> $stable(fill_data))
        else begin
            errors++;
            $display("Error: o_fill_data expected %0h got %0h", $past(fill_data),
                     $sampled(fill_data));
        end
    assert property (@(posedge clk) disable iff (rst)
                     fill_valid && !fill_ready |=> $stable(fill_dirty))
        else begin
            errors++;
            $display("Error: o_fill_dirty expected %0h got %0h", $past(fill_dirty),
                     $sampled(fill_dirty));
        end

    // The reference model samples 1 ns after the falling edge once everything has settled
    // A request is applied before a fill of the same edge, as a load hit joins that fill
    always begin : ref_model
        logic [LINE_W-1:0] line_tmp;
        @(negedge clk);
        #1;
        if (!rst) begin
            if (wb_cyc && wb_ack) acks++;
            if (req_valid && req_ready) begin
                requests++;
                if (!exp_line.exists(req_addr)) begin
                    exp_line[req_addr]  = mem_line(req_addr);
                    exp_dirty[req_addr] = 1'b0;
                end
                line_tmp = exp_line[req_addr];
                for (int b = 0; b < LINE_SIZE; b++) begin
                    if (req_we && req_byte_sel[b]) begin
                        line_tmp[b*8 +: 8] = req_wr_data[b*8 +: 8];
                    end
                end
                exp_line[req_addr]  = line_tmp;
                exp_dirty[req_addr] = exp_dirty[req_addr] | req_we;
            end
            if (fill_valid && fill_ready) begin
                fills++;
                assert (exp_line.exists(fill_addr)) else begin
                    errors++;
                    $display("A fill for line %0h arrived with no miss pending", fill_addr);
                end
                if (exp_line.exists(fill_addr)) begin
                    expect_equal("o_fill_data", fill_data, exp_line[fill_addr]);
                    expect_equal("o_fill_dirty", fill_dirty, exp_dirty[fill_addr]);
                    exp_line.delete(fill_addr);
                    exp_dirty.delete(fill_addr);
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("The DUT hung, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors=%0d requests=%0d fills=%0d", errors, requests, fills);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        int                     base;
        int                     quiet;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      data;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_we       = 1'b0;
        req_addr     = '0;
        req_wr_data  = '0;
        req_byte_sel = '0;
        fill_ready   = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        expect_equal("o_wb_cyc", wb_cyc, 0);
        expect_equal("o_wb_stb", wb_stb, 0);
        expect_equal("o_fill_valid", fill_valid, 0);
        expect_equal("o_req_ready", req_ready, 1);
        @(negedge clk);

        // A single load miss must fill with plain memory data and a clean dirty bit
        send_request(1'b0, LINE_ADDR_W'(28'h0001000), '0, '0);
        while (fills < 1) @(negedge clk);

        // Stores merge into a pending line and the last one lands on the done cycle
        base = acks;
        addr = LINE_ADDR_W'(28'h0001001);
        send_request(1'b0, addr, '0, '0);
        send_request(1'b1, addr, 128'h11112222_33334444_55556666_77778888, 16'h00f0);
        send_request(1'b0, addr, '0, 16'hffff);
        while (acks < base + BEATS) @(negedge clk);
        send_request(1'b1, addr, {16{8'ha5}}, 16'h0ff0);
        while (fills < 2) @(negedge clk);

        // With the fill port stalled four distinct lines fill the whole queue
        fill_ready = 1'b0;
        base = acks;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            send_request(1'b0, LINE_ADDR_W'(28'h0002000 + i), '0, '0);
        end
        req_valid = 1'b1;
        req_we    = 1'b0;
        req_addr  = LINE_ADDR_W'(28'h0002000 + MHQ_DEPTH);
        while (acks < base + MHQ_DEPTH * BEATS) begin
            #1;
            expect_equal("o_req_ready", req_ready, 0);
            @(negedge clk);
        end
        // Done follows the last ack and complete comes on the edge after it
        repeat (2) @(negedge clk);
        req_addr = LINE_ADDR_W'(28'h0002002);
        #1;
        expect_equal("o_req_ready", req_ready, 1);
        @(negedge clk);
        req_valid = 1'b0;
        repeat (3) @(negedge clk);
        fill_ready = 1'b1;
        while (fills < 2 + MHQ_DEPTH) @(negedge clk);
        send_request(1'b0, LINE_ADDR_W'(28'h0002000 + MHQ_DEPTH), '0, '0);

        // Random loads and stores use a small pool of lines so that many of them merge
        for (int n = 0; n < 28; n++) begin
            rng  = next_random(rng);
            addr = LINE_ADDR_W'(28'h0003000) + LINE_ADDR_W'(rng % 6);
            base = int'(rng[18:17]);
            for (int w = 0; w < LINE_W / 32; w++) begin
                rng              = next_random(rng);
                data[w*32 +: 32] = rng;
            end
            send_request(rng[5], addr, data, rng[31:16]);
            repeat (base) @(negedge clk);
        end

        // Drain until the bus and the fill port have been idle for a while
        quiet = 0;
        while (quiet < 16) begin
            @(negedge clk);
            #1;
            quiet = (wb_cyc || fill_valid) ? 0 : quiet + 1;
        end
        assert (exp_line.num() == 0) else begin
            errors++;
            $display("%0d allocated lines were never filled", exp_line.num());
        end
        $display("errors=%0d requests=%0d fills=%0d", errors, requests, fills);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 20.0
)(
    output logic o_clk
);

    // Free-running clock that starts low, so the first rising edge is at half a period
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

// ==== sim/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model #(
    parameter int          ADDR_WIDTH = 32,
    parameter logic [31:0] SEED       = 32'h98a71709,
    parameter logic [31:0] DATA_XOR   = 32'h5a5a0000
)(
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic [ADDR_WIDTH-1:0]             i_wb_adr,
    output logic [mhq_pkg::WB_DATA_WIDTH-1:0] o_wb_dat,
    output logic                              o_wb_ack
);

    logic [31:0]                       rng;
    logic [31:0]                       rng_next;
    logic [1:0]                        wait_cnt;
    logic                              ack_r = 1'b0;
    logic [mhq_pkg::WB_DATA_WIDTH-1:0] dat_r = '0;

    // Xorshift step, its low two bits set the wait states of the next beat
    function automatic logic [31:0] advance_rng(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign rng_next = advance_rng(rng);

    // Ack is registered and lasts one cycle, then a fresh wait count is drawn
    // Every cycle is a read, the word is its own byte address XORed with a constant
    always @(posedge clk) begin
        if (i_rst) begin
            rng      <= SEED;
            wait_cnt <= SEED[1:0];
            ack_r    <= 1'b0;
        end else if (ack_r) begin
            ack_r    <= 1'b0;
            rng      <= rng_next;
            wait_cnt <= rng_next[1:0];
        end else if (i_wb_cyc && i_wb_stb) begin
            if (wait_cnt == 2'd0) begin
                ack_r <= 1'b1;
                dat_r <= mhq_pkg::WB_DATA_WIDTH'(i_wb_adr) ^ DATA_XOR;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    assign o_wb_ack = ack_r;
    assign o_wb_dat = dat_r;

endmodule
